// File: decode_stage.f
rtl/rv_decode_pkg.sv
rtl/instr_fetch.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/issue_scoreboard.sv
rtl/decode_stage.sv
dv/clk_gen.sv
dv/decode_stage_tb.sv

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
	import rv_decode_pkg::*;

	localparam int N_ISSUE   = 400;
	localparam int TIMEOUT   = 20000;
	localparam int RST_LIMIT = 100;

	// expected decode of one word
	typedef struct packed {
		b_sel_t     b_sel;
		logic       we;
		fn_sel_e    fn;
		alu_fn_t    alu_fn;
		logic       j;
		logic       jr;
		logic       bneq;
		logic       btype;
		logic       lui;
		logic       auipc;
		mem_op_e    mem_op;
		logic [2:0] mul_div_op;
		pc_sel_t    pc_sel;
		logic       ecall;
		logic       rs1_used;
		logic       rs2_used;
		word_t      imm;
	} ctrl_t;

	logic        clk;
	logic        rst;
	// dut inputs
	instr_t      wb_dat;
	logic        wb_ack;
	logic        ex_ready;
	logic        wb_valid;
	reg_idx_t    wb_rd;
	// dut outputs
	logic        wb_cyc;
	logic        wb_stb;
	logic [11:0] wb_adr;
	logic        ex_valid;
	word_t       ex_pc;
	instr_t      ex_instr;
	reg_idx_t    ex_rd;
	reg_idx_t    ex_rs1;
	reg_idx_t    ex_rs2;
	word_t       ex_imm;
	b_sel_t      ex_b_sel;
	logic        ex_we;
	fn_sel_e     ex_fn;
	alu_fn_t     ex_alu_fn;
	logic        ex_j;
	logic        ex_jr;
	logic        ex_bneq;
	logic        ex_btype;
	logic        ex_lui;
	logic        ex_auipc;
	mem_op_e     ex_mem_op;
	logic [2:0]  ex_mul_div_op;
	pc_sel_t     ex_pc_sel;
	logic        ex_ecall;

	instr_t      prog [256];
	// separate random streams per process
	logic [31:0] mem_rng;
	logic [31:0] ex_rng;
	int          mem_wait;
	bit          mem_busy;
	int          wb_gap;
	reg_idx_t    wb_queue [$];

	// monitor state
	int          errors;
	int          checks;
	int          issued_cnt;
	word_t       exp_pc;
	word_t       fetch_pc;
	logic [31:0] model_busy;
	logic        prev_rst;
	logic        prev_ex_valid;
	logic        prev_ex_ready;
	logic        prev_cyc;
	logic        prev_ack;
	logic [11:0] prev_adr;
	logic        prev_wb_valid;
	reg_idx_t    prev_wb_rd;
	logic [136:0] prev_bundle;

	clk_gen u_clk_gen (
		.o_clk   (clk),
		.o_reset (rst)
	);

	decode_stage #(
		.ADDR_W (12)
	) u_decode_stage (
		.i_clk           (clk),
		.i_reset         (rst),
		.o_wb_cyc        (wb_cyc),
		.o_wb_stb        (wb_stb),
		.o_wb_adr        (wb_adr),
		.i_wb_dat        (wb_dat),
		.i_wb_ack        (wb_ack),
		.i_ex_ready      (ex_ready),
		.i_wb_valid      (wb_valid),
		.i_wb_rd         (wb_rd),
		.o_ex_valid      (ex_valid),
		.o_ex_pc         (ex_pc),
		.o_ex_instr      (ex_instr),
		.o_ex_rd         (ex_rd),
		.o_ex_rs1        (ex_rs1),
		.o_ex_rs2        (ex_rs2),
		.o_ex_imm        (ex_imm),
		.o_ex_b_sel      (ex_b_sel),
		.o_ex_we         (ex_we),
		.o_ex_fn         (ex_fn),
		.o_ex_alu_fn     (ex_alu_fn),
		.o_ex_j          (ex_j),
		.o_ex_jr         (ex_jr),
		.o_ex_bneq       (ex_bneq),
		.o_ex_btype      (ex_btype),
		.o_ex_lui        (ex_lui),
		.o_ex_auipc      (ex_auipc),
		.o_ex_mem_op     (ex_mem_op),
		.o_ex_mul_div_op (ex_mul_div_op),
		.o_ex_pc_sel     (ex_pc_sel),
		.o_ex_ecall      (ex_ecall)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// control fields by opcode class, straight from the code tables
	function automatic ctrl_t model_decode(input instr_t w);
		ctrl_t      c;
		logic [2:0] f3;
		f3 = w[14:12];
		c = '0;
		case (w[6:0])
			OP_REG: begin
				c.we = 1'b1;
				if (w[31:25] == 7'b0000001) begin
					c.fn = FN_MULDIV;
					c.mul_div_op = f3;
				end
				// sub and sra carry bit 30
				c.alu_fn = {w[30] & (f3 == 3'd0 || f3 == 3'd5), f3};
				c.rs1_used = 1'b1;
				c.rs2_used = 1'b1;
			end
			OP_IMM: begin
				c.we = 1'b1;
				c.alu_fn = {w[30] & (f3 == 3'd5), f3};
				c.b_sel = (f3 == 3'd1 || f3 == 3'd5) ? BSEL_SHAMT : BSEL_IMM;
				c.rs1_used = 1'b1;
				c.imm = {{21{w[31]}}, w[30:20]};
			end
			OP_LOAD: begin
				c.we = 1'b1;
				c.fn = FN_LOAD_SYS;
				c.b_sel = BSEL_IMM;
				case (f3)
					3'd0:    c.mem_op = MEM_LB;
					3'd1:    c.mem_op = MEM_LH;
					3'd2:    c.mem_op = MEM_LW;
					3'd4:    c.mem_op = MEM_LBU;
					3'd5:    c.mem_op = MEM_LHU;
					default: c.mem_op = MEM_NONE;
				endcase
				c.rs1_used = 1'b1;
				c.imm = {{21{w[31]}}, w[30:20]};
			end
			OP_STORE: begin
				case (f3)
					3'd0:    c.mem_op = MEM_SB;
					3'd1:    c.mem_op = MEM_SH;
					3'd2:    c.mem_op = MEM_SW;
					default: c.mem_op = MEM_NONE;
				endcase
				c.rs1_used = 1'b1;
				c.rs2_used = 1'b1;
				c.imm = {{21{w[31]}}, w[30:25], w[11:7]};
			end
			OP_BRANCH: begin
				c.btype = 1'b1;
				c.bneq = (f3 == 3'd1);
				case (f3)
					3'd0, 3'd1: c.alu_fn = 4'd8;
					3'd4:       c.alu_fn = 4'd2;
					3'd6:       c.alu_fn = 4'd3;
					3'd5:       c.alu_fn = 4'd9;
					3'd7:       c.alu_fn = 4'd10;
					default:    c.alu_fn = 4'd0;
				endcase
				c.pc_sel = PCSEL_JUMP;
				c.rs1_used = 1'b1;
				c.rs2_used = 1'b1;
				c.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			end
			OP_JAL: begin
				c.we = 1'b1;
				c.j = 1'b1;
				c.fn = FN_PC4;
				c.pc_sel = PCSEL_JUMP;
				c.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			OP_JALR: begin
				if (f3 == 3'd0) begin
					c.we = 1'b1;
					c.jr = 1'b1;
					c.fn = FN_PC4;
					c.pc_sel = PCSEL_JUMP;
					c.b_sel = BSEL_IMM;
				end
				c.rs1_used = 1'b1;
				c.imm = {{21{w[31]}}, w[30:20]};
			end
			OP_LUI: begin
				c.we = 1'b1;
				c.lui = 1'b1;
				c.fn = FN_IMM;
				c.imm = {w[31:12], 12'h000};
			end
			OP_AUIPC: begin
				c.we = 1'b1;
				c.auipc = 1'b1;
				c.fn = FN_AUIPC;
				c.imm = {w[31:12], 12'h000};
			end
			OP_SYSTEM: begin
				c.we = 1'b1;
				c.fn = FN_LOAD_SYS;
				c.ecall = (f3 == 3'd0) && (w[31:20] == 12'd0);
				c.rs1_used = 1'b1;
				c.imm = {{21{w[31]}}, w[30:20]};
			end
			default: c = '0;
		endcase
		return c;
	endfunction

	function automatic logic [136:0] ex_bundle();
		return {ex_pc, ex_instr, ex_rd, ex_rs1, ex_rs2, ex_imm, ex_b_sel, ex_we, ex_fn,
			ex_alu_fn, ex_j, ex_jr, ex_bneq, ex_btype, ex_lui, ex_auipc, ex_mem_op,
			ex_mul_div_op, ex_pc_sel, ex_ecall};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	// random program, registers x0..x7 so hazards are frequent
	task automatic fill_program();
		logic [31:0] rng;
		logic [31:0] fld;
		int          cls;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [2:0]  f3;
		logic [2:0]  lf3 [5];
		logic [2:0]  bf3 [6];
		lf3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		bf3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		rng = 32'd13;
		for (int i = 0; i < 256; i++) begin
			rng = xorshift32(rng);
			cls = rng % 11;
			rng = xorshift32(rng);
			fld = rng;
			rd  = {2'b00, fld[2:0]};
			rs1 = {2'b00, fld[5:3]};
			rs2 = {2'b00, fld[8:6]};
			f3  = fld[11:9];
			case (cls)
				0: prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && fld[12]) ? 7'b0100000 : 7'b0,
					rs2, rs1, f3, rd, OP_REG};
				// every m-extension operation
				1: prog[i] = {7'b0000001, rs2, rs1, f3, rd, OP_REG};
				2: begin
					if (f3 == 3'd1)
						prog[i] = {7'b0, fld[16:12], rs1, f3, rd, OP_IMM};
					else if (f3 == 3'd5)
						prog[i] = {fld[17] ? 7'b0100000 : 7'b0, fld[16:12], rs1, f3, rd, OP_IMM};
					else
						prog[i] = {fld[31:20], rs1, f3, rd, OP_IMM};
				end
				3: prog[i] = {fld[31:20], rs1, lf3[fld[11:9] % 5], rd, OP_LOAD};
				4: prog[i] = {fld[31:25], rs2, rs1, 3'(fld[11:9] % 3), fld[16:12], OP_STORE};
				5: prog[i] = {fld[31:25], rs2, rs1, bf3[fld[11:9] % 6], fld[16:12], OP_BRANCH};
				6: prog[i] = {fld[31:12], rd, OP_JAL};
				7: prog[i] = {fld[31:20], rs1, 3'b000, rd, OP_JALR};
				8: prog[i] = {fld[31:12], rd, OP_LUI};
				9: prog[i] = {fld[31:12], rd, OP_AUIPC};
				default: prog[i] = 32'h0000_0073;
			endcase
		end
		// remaining streams continue from the program stream
		mem_rng = xorshift32(rng ^ 32'h0000_5a5a);
		ex_rng  = xorshift32(mem_rng ^ 32'h0000_a5a5);
	endtask

	// bundle just issued, sources checked against busy before the edge
	task automatic check_issued(input logic [31:0] busy_before);
		ctrl_t  want;
		instr_t w;
		w = prog[exp_pc[9:2]];
		want = model_decode(w);
		check_value("o_ex_pc", ex_pc, exp_pc);
		check_value("o_ex_instr", ex_instr, w);
		check_value("o_ex_rd", ex_rd, w[11:7]);
		check_value("o_ex_rs1", ex_rs1, w[19:15]);
		check_value("o_ex_rs2", ex_rs2, w[24:20]);
		check_value("o_ex_imm", ex_imm, want.imm);
		check_value("o_ex_b_sel", ex_b_sel, want.b_sel);
		check_value("o_ex_we", ex_we, want.we);
		check_value("o_ex_fn", ex_fn, want.fn);
		check_value("o_ex_alu_fn", ex_alu_fn, want.alu_fn);
		check_value("o_ex_j", ex_j, want.j);
		check_value("o_ex_jr", ex_jr, want.jr);
		check_value("o_ex_bneq", ex_bneq, want.bneq);
		check_value("o_ex_btype", ex_btype, want.btype);
		check_value("o_ex_lui", ex_lui, want.lui);
		check_value("o_ex_auipc", ex_auipc, want.auipc);
		check_value("o_ex_mem_op", ex_mem_op, want.mem_op);
		check_value("o_ex_mul_div_op", ex_mul_div_op, want.mul_div_op);
		check_value("o_ex_pc_sel", ex_pc_sel, want.pc_sel);
		check_value("o_ex_ecall", ex_ecall, want.ecall);
		checks++;
		assert (!(want.rs1_used && busy_before[w[19:15]]) &&
			!(want.rs2_used && busy_before[w[24:20]])) else begin
			errors++;
			$display("instruction at pc 0x%h issued while a source register was pending",
				exp_pc);
		end
	endtask

	// instruction memory, ack after 0 to 3 extra cycles
	always @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			mem_busy = 1'b0;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
			mem_busy = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_rng = xorshift32(mem_rng);
				mem_wait = mem_rng % 4;
			end
			if (mem_wait == 0) begin
				wb_ack <= 1'b1;
				wb_dat <= prog[wb_adr[9:2]];
			end else begin
				mem_wait--;
			end
		end
	end

	// execute back-pressure and writeback notices
	always @(posedge clk) begin
		if (rst) begin
			ex_ready <= 1'b0;
			wb_valid <= 1'b0;
			wb_rd <= '0;
			wb_gap = 0;
		end else begin
			ex_rng = xorshift32(ex_rng);
			ex_ready <= (ex_rng[1:0] != 2'b00);
			if (wb_gap != 0) begin
				wb_gap--;
				wb_valid <= 1'b0;
			end else if (wb_queue.size() > 0) begin
				wb_valid <= 1'b1;
				wb_rd <= wb_queue.pop_front();
				wb_gap = ex_rng[5:4];
			end else begin
				wb_valid <= 1'b0;
			end
		end
	end

	// monitor on the falling edge, all signals settled
	always @(negedge clk) begin
		logic [31:0] next_busy;
		instr_t      iw;
		ctrl_t       ic;
		if (rst) begin
			model_busy = '0;
			exp_pc = '0;
			fetch_pc = '0;
		end else begin
			// first cycle out of reset
			if (prev_rst === 1'b1) begin
				check_value("o_wb_cyc", wb_cyc, 1'b0);
				check_value("o_wb_stb", wb_stb, 1'b0);
				check_value("o_ex_valid", ex_valid, 1'b0);
			end
			// wishbone classic read
			if (prev_cyc && prev_ack) begin
				fetch_pc = fetch_pc + 32'd4;
				check_value("o_wb_cyc", wb_cyc, 1'b0);
			end else if (prev_cyc) begin
				checks++;
				assert (wb_cyc && wb_stb && wb_adr == prev_adr) else begin
					errors++;
					$display("request dropped or address moved before ack");
				end
			end
			if (wb_cyc) begin
				check_value("o_wb_stb", wb_stb, 1'b1);
				check_value("o_wb_adr", wb_adr, fetch_pc[11:0]);
			end
			// clears from last cycle's writeback
			next_busy = model_busy;
			if (prev_wb_valid)
				next_busy[prev_wb_rd] = 1'b0;
			if (prev_ex_valid && !prev_ex_ready) begin
				check_value("o_ex_valid", ex_valid, 1'b1);
				checks++;
				assert (ex_bundle() === prev_bundle) else begin
					errors++;
					$display("[ERROR] o_ex bundle got 0x%h expected 0x%h", ex_bundle(),
						prev_bundle);
				end
			end else if (ex_valid) begin
				check_issued(model_busy);
				// destination from the model decode, set wins over the clear
				iw = prog[exp_pc[9:2]];
				ic = model_decode(iw);
				if (ic.we && iw[11:7] != 5'd0) begin
					next_busy[iw[11:7]] = 1'b1;
					wb_queue.push_back(iw[11:7]);
				end
				exp_pc = exp_pc + 32'd4;
				issued_cnt++;
			end
			next_busy[0] = 1'b0;
			model_busy = next_busy;
		end
		prev_rst = rst;
		prev_ex_valid = ex_valid;
		prev_ex_ready = ex_ready;
		prev_cyc = wb_cyc;
		prev_ack = wb_ack;
		prev_adr = wb_adr;
		prev_wb_valid = wb_valid;
		prev_wb_rd = wb_rd;
		prev_bundle = ex_bundle();
	end

	task automatic finish_run();
		$display("errors: %0d in %0d checks, %0d instructions issued", errors, checks,
			issued_cnt);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	endtask

	initial begin
		int cycles;
		errors = 0;
		checks = 0;
		issued_cnt = 0;
		wb_dat = '0;
		wb_ack = 1'b0;
		ex_ready = 1'b0;
		wb_valid = 1'b0;
		wb_rd = '0;
		fill_program();
		cycles = 0;
		while (rst !== 1'b0 && cycles < RST_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			errors++;
			$display("reset was never released");
		end else begin
			cycles = 0;
			while (issued_cnt < N_ISSUE && cycles < TIMEOUT) begin
				@(posedge clk);
				cycles++;
			end
			if (issued_cnt < N_ISSUE) begin
				errors++;
				$display("timeout after %0d cycles with %0d instructions issued", cycles,
					issued_cnt);
			end
		end
		finish_run();
	end

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic o_clk,
	output logic o_reset
);

	// 8 ns period, first rising edge at 4 ns
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// reset held for 8 rising edges
	initial begin
		o_reset = 1'b1;
		repeat (8) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
	parameter int ADDR_W = 12
) (
	input  logic                     i_clk,
	input  logic                     i_reset,
	// instruction memory, wishbone classic
	output logic                     o_wb_cyc,
	output logic                     o_wb_stb,
	output logic [ADDR_W-1:0]        o_wb_adr,
	input  rv_decode_pkg::instr_t    i_wb_dat,
	input  logic                     i_wb_ack,
	// execute handshake
	input  logic                     i_ex_ready,
	// writeback notices
	input  logic                     i_wb_valid,
	input  rv_decode_pkg::reg_idx_t  i_wb_rd,
	output logic                     o_ex_valid,
	output rv_decode_pkg::word_t     o_ex_pc,
	output rv_decode_pkg::instr_t    o_ex_instr,
	output rv_decode_pkg::reg_idx_t  o_ex_rd,
	output rv_decode_pkg::reg_idx_t  o_ex_rs1,
	output rv_decode_pkg::reg_idx_t  o_ex_rs2,
	output rv_decode_pkg::word_t     o_ex_imm,
	output rv_decode_pkg::b_sel_t    o_ex_b_sel,
	output logic                     o_ex_we,
	output rv_decode_pkg::fn_sel_e   o_ex_fn,
	output rv_decode_pkg::alu_fn_t   o_ex_alu_fn,
	output logic                     o_ex_j,
	output logic                     o_ex_jr,
	output logic                     o_ex_bneq,
	output logic                     o_ex_btype,
	output logic                     o_ex_lui,
	output logic                     o_ex_auipc,
	output rv_decode_pkg::mem_op_e   o_ex_mem_op,
	output logic [2:0]               o_ex_mul_div_op,
	output rv_decode_pkg::pc_sel_t   o_ex_pc_sel,
	output logic                     o_ex_ecall
);
	import rv_decode_pkg::*;

	// fetch buffer
	logic     f_valid;
	instr_t   f_instr;
	word_t    f_pc;
	// scoreboard feedback
	logic     issue;
	logic     hazard;
	// decode of f_instr
	b_sel_t   d_b_sel;
	logic     d_we;
	fn_sel_e  d_fn;
	alu_fn_t  d_alu_fn;
	logic     d_j;
	logic     d_jr;
	logic     d_bneq;
	logic     d_btype;
	logic     d_lui;
	logic     d_auipc;
	mem_op_e  d_mem_op;
	logic [2:0] d_mul_div_op;
	pc_sel_t  d_pc_sel;
	logic     d_ecall;
	logic     d_rs1_used;
	logic     d_rs2_used;
	word_t    d_imm;

	instr_fetch #(
		.ADDR_W (ADDR_W)
	) u_instr_fetch (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.o_wb_cyc (o_wb_cyc),
		.o_wb_stb (o_wb_stb),
		.o_wb_adr (o_wb_adr),
		.i_wb_dat (i_wb_dat),
		.i_wb_ack (i_wb_ack),
		.i_issue  (issue),
		.o_valid  (f_valid),
		.o_instr  (f_instr),
		.o_pc     (f_pc)
	);

	// stall comes back from the scoreboard hazard
	instr_decoder u_instr_decoder (
		.i_instr      (f_instr),
		.i_stall      (hazard),
		.o_b_sel      (d_b_sel),
		.o_we         (d_we),
		.o_fn         (d_fn),
		.o_alu_fn     (d_alu_fn),
		.o_j          (d_j),
		.o_jr         (d_jr),
		.o_bneq       (d_bneq),
		.o_btype      (d_btype),
		.o_lui        (d_lui),
		.o_auipc      (d_auipc),
		.o_mem_op     (d_mem_op),
		.o_mul_div_op (d_mul_div_op),
		.o_pc_sel     (d_pc_sel),
		.o_ecall      (d_ecall),
		.o_rs1_used   (d_rs1_used),
		.o_rs2_used   (d_rs2_used)
	);

	imm_gen u_imm_gen (
		.i_instr (f_instr),
		.o_imm   (d_imm)
	);

	issue_scoreboard u_issue_scoreboard (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_valid         (f_valid),
		.i_instr         (f_instr),
		.i_pc            (f_pc),
		.i_imm           (d_imm),
		.i_we            (d_we),
		.i_rs1_used      (d_rs1_used),
		.i_rs2_used      (d_rs2_used),
		.i_b_sel         (d_b_sel),
		.i_fn            (d_fn),
		.i_alu_fn        (d_alu_fn),
		.i_j             (d_j),
		.i_jr            (d_jr),
		.i_bneq          (d_bneq),
		.i_btype         (d_btype),
		.i_lui           (d_lui),
		.i_auipc         (d_auipc),
		.i_mem_op        (d_mem_op),
		.i_mul_div_op    (d_mul_div_op),
		.i_pc_sel        (d_pc_sel),
		.i_ecall         (d_ecall),
		.i_ex_ready      (i_ex_ready),
		.i_wb_valid      (i_wb_valid),
		.i_wb_rd         (i_wb_rd),
		.o_issue         (issue),
		.o_hazard        (hazard),
		.o_ex_valid      (o_ex_valid),
		.o_ex_pc         (o_ex_pc),
		.o_ex_instr      (o_ex_instr),
		.o_ex_rd         (o_ex_rd),
		.o_ex_rs1        (o_ex_rs1),
		.o_ex_rs2        (o_ex_rs2),
		.o_ex_imm        (o_ex_imm),
		.o_ex_b_sel      (o_ex_b_sel),
		.o_ex_we         (o_ex_we),
		.o_ex_fn         (o_ex_fn),
		.o_ex_alu_fn     (o_ex_alu_fn),
		.o_ex_j          (o_ex_j),
		.o_ex_jr         (o_ex_jr),
		.o_ex_bneq       (o_ex_bneq),
		.o_ex_btype      (o_ex_btype),
		.o_ex_lui        (o_ex_lui),
		.o_ex_auipc      (o_ex_auipc),
		.o_ex_mem_op     (o_ex_mem_op),
		.o_ex_mul_div_op (o_ex_mul_div_op),
		.o_ex_pc_sel     (o_ex_pc_sel),
		.o_ex_ecall      (o_ex_ecall)
	);

endmodule

// File: rtl/issue_scoreboard.sv
`timescale 1ns/1ps

module issue_scoreboard (
	input  logic                     i_clk,
	input  logic                     i_reset,
	// fetched word and its decode
	input  logic                     i_valid,
	input  rv_decode_pkg::instr_t    i_instr,
	input  rv_decode_pkg::word_t     i_pc,
	input  rv_decode_pkg::word_t     i_imm,
	input  logic                     i_we,
	input  logic                     i_rs1_used,
	input  logic                     i_rs2_used,
	input  rv_decode_pkg::b_sel_t    i_b_sel,
	input  rv_decode_pkg::fn_sel_e   i_fn,
	input  rv_decode_pkg::alu_fn_t   i_alu_fn,
	input  logic                     i_j,
	input  logic                     i_jr,
	input  logic                     i_bneq,
	input  logic                     i_btype,
	input  logic                     i_lui,
	input  logic                     i_auipc,
	input  rv_decode_pkg::mem_op_e   i_mem_op,
	input  logic [2:0]               i_mul_div_op,
	input  rv_decode_pkg::pc_sel_t   i_pc_sel,
	input  logic                     i_ecall,
	// execute and writeback side
	input  logic                     i_ex_ready,
	input  logic                     i_wb_valid,
	input  rv_decode_pkg::reg_idx_t  i_wb_rd,
	output logic                     o_issue,
	output logic                     o_hazard,
	output logic                     o_ex_valid,
	output rv_decode_pkg::word_t     o_ex_pc,
	output rv_decode_pkg::instr_t    o_ex_instr,
	output rv_decode_pkg::reg_idx_t  o_ex_rd,
	output rv_decode_pkg::reg_idx_t  o_ex_rs1,
	output rv_decode_pkg::reg_idx_t  o_ex_rs2,
	output rv_decode_pkg::word_t     o_ex_imm,
	output rv_decode_pkg::b_sel_t    o_ex_b_sel,
	output logic                     o_ex_we,
	output rv_decode_pkg::fn_sel_e   o_ex_fn,
	output rv_decode_pkg::alu_fn_t   o_ex_alu_fn,
	output logic                     o_ex_j,
	output logic                     o_ex_jr,
	output logic                     o_ex_bneq,
	output logic                     o_ex_btype,
	output logic                     o_ex_lui,
	output logic                     o_ex_auipc,
	output rv_decode_pkg::mem_op_e   o_ex_mem_op,
	output logic [2:0]               o_ex_mul_div_op,
	output rv_decode_pkg::pc_sel_t   o_ex_pc_sel,
	output logic                     o_ex_ecall
);
	import rv_decode_pkg::*;

	// x0 never busy
	logic [31:1] busy;
	logic [31:0] busy_vec;
	reg_idx_t    rs1;
	reg_idx_t    rs2;
	reg_idx_t    rd;
	logic        rs1_busy;
	logic        rs2_busy;
	logic [31:0] set_mask;
	logic [31:0] clr_mask;

	assign rd  = i_instr[11:7];
	assign rs1 = i_instr[19:15];
	assign rs2 = i_instr[24:20];

	assign busy_vec = {busy, 1'b0};
	assign rs1_busy = i_rs1_used & busy_vec[rs1];
	assign rs2_busy = i_rs2_used & busy_vec[rs2];

	assign o_hazard = i_valid & (rs1_busy | rs2_busy);
	// output slot free now or draining this cycle
	assign o_issue  = i_valid & ~(rs1_busy | rs2_busy) & (~o_ex_valid | i_ex_ready);

	// a shift into bit 0 falls off below
	assign set_mask = (o_issue & i_we) ? (32'd1 << rd) : 32'd0;
	assign clr_mask = i_wb_valid ? (32'd1 << i_wb_rd) : 32'd0;

	// set wins over a same-cycle clear
	always_ff @(posedge i_clk) begin
		if (i_reset)
			busy <= '0;
		else
			busy <= (busy & ~clr_mask[31:1]) | set_mask[31:1];
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_ex_valid <= 1'b0;
		else if (o_issue)
			o_ex_valid <= 1'b1;
		else if (i_ex_ready)
			o_ex_valid <= 1'b0;
	end

	// bundle only moves at issue, so it holds under back-pressure
	always_ff @(posedge i_clk) begin
		if (o_issue) begin
			o_ex_pc         <= i_pc;
			o_ex_instr      <= i_instr;
			o_ex_rd         <= rd;
			o_ex_rs1        <= rs1;
			o_ex_rs2        <= rs2;
			o_ex_imm        <= i_imm;
			o_ex_b_sel      <= i_b_sel;
			o_ex_we         <= i_we;
			o_ex_fn         <= i_fn;
			o_ex_alu_fn     <= i_alu_fn;
			o_ex_j          <= i_j;
			o_ex_jr         <= i_jr;
			o_ex_bneq       <= i_bneq;
			o_ex_btype      <= i_btype;
			o_ex_lui        <= i_lui;
			o_ex_auipc      <= i_auipc;
			o_ex_mem_op     <= i_mem_op;
			o_ex_mul_div_op <= i_mul_div_op;
			o_ex_pc_sel     <= i_pc_sel;
			o_ex_ecall      <= i_ecall;
		end
	end

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  rv_decode_pkg::instr_t i_instr,
	output rv_decode_pkg::word_t  o_imm
);
	import rv_decode_pkg::*;

	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	// sign bit is always instr[31]
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	// b and j are halfword offsets
	assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'd0};
	assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	// format by opcode, r-type and unknown give zero
	always_comb begin
		case (i_instr[6:0])
			OP_IMM, OP_LOAD, OP_JALR, OP_SYSTEM: o_imm = imm_i;
			OP_STORE:                            o_imm = imm_s;
			OP_BRANCH:                           o_imm = imm_b;
			OP_LUI, OP_AUIPC:                    o_imm = imm_u;
			OP_JAL:                              o_imm = imm_j;
			default:                             o_imm = '0;
		endcase
	end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  rv_decode_pkg::instr_t  i_instr,
	// hazard from the scoreboard
	input  logic                   i_stall,
	output rv_decode_pkg::b_sel_t  o_b_sel,
	output logic                   o_we,
	output rv_decode_pkg::fn_sel_e o_fn,
	output rv_decode_pkg::alu_fn_t o_alu_fn,
	output logic                   o_j,
	output logic                   o_jr,
	output logic                   o_bneq,
	output logic                   o_btype,
	output logic                   o_lui,
	output logic                   o_auipc,
	output rv_decode_pkg::mem_op_e o_mem_op,
	output logic [2:0]             o_mul_div_op,
	output rv_decode_pkg::pc_sel_t o_pc_sel,
	output logic                   o_ecall,
	output logic                   o_rs1_used,
	output logic                   o_rs2_used
);
	import rv_decode_pkg::*;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        instr_30;

	// instruction types, one-hot by opcode
	logic rtype;
	logic itype;
	logic ltype;
	logic stype;
	logic btype;
	logic jtype;
	logic jrtype;
	logic lui_op;
	logic auipc_op;
	logic system;

	logic mul_div;
	logic jalr;
	logic shift_imm;
	logic arith_30;

	assign opcode   = i_instr[6:0];
	assign funct3   = i_instr[14:12];
	assign funct7   = i_instr[31:25];
	assign funct12  = i_instr[31:20];
	assign instr_30 = i_instr[30];

	assign rtype    = (opcode == OP_REG);
	assign itype    = (opcode == OP_IMM);
	assign ltype    = (opcode == OP_LOAD);
	assign stype    = (opcode == OP_STORE);
	assign btype    = (opcode == OP_BRANCH);
	assign jtype    = (opcode == OP_JAL);
	assign jrtype   = (opcode == OP_JALR);
	assign lui_op   = (opcode == OP_LUI);
	assign auipc_op = (opcode == OP_AUIPC);
	assign system   = (opcode == OP_SYSTEM);

	// m extension, funct7 = 0000001
	assign mul_div   = rtype & (funct7 == 7'b0000001);
	// jalr only with funct3 000
	assign jalr      = jrtype & (funct3 == 3'b000);
	// slli 001, srli and srai 101
	assign shift_imm = itype & (funct3[1:0] == 2'b01);
	// bit 30 only matters for sub, sra and srai
	assign arith_30  = instr_30 & ((funct3 == 3'b101) | (rtype & (funct3 == 3'b000)));

	// alu function
	always_comb begin
		o_alu_fn = 4'd0;
		if (rtype | itype) begin
			o_alu_fn = {arith_30, funct3};
		end else if (btype) begin
			case (funct3)
				// beq and bne share the subtract compare
				3'b000, 3'b001: o_alu_fn = 4'd8;
				3'b100:         o_alu_fn = 4'd2;
				3'b110:         o_alu_fn = 4'd3;
				3'b101:         o_alu_fn = 4'd9;
				3'b111:         o_alu_fn = 4'd10;
				default:        o_alu_fn = 4'd0;
			endcase
		end
	end

	// result source, types never overlap
	always_comb begin
		o_fn = FN_ALU;
		if (jtype | jalr)
			o_fn = FN_PC4;
		else if (mul_div)
			o_fn = FN_MULDIV;
		else if (lui_op)
			o_fn = FN_IMM;
		else if (auipc_op)
			o_fn = FN_AUIPC;
		else if (ltype | system)
			o_fn = FN_LOAD_SYS;
	end

	// load and store width
	always_comb begin
		o_mem_op = MEM_NONE;
		if (ltype) begin
			case (funct3)
				3'b000:  o_mem_op = MEM_LB;
				3'b001:  o_mem_op = MEM_LH;
				3'b010:  o_mem_op = MEM_LW;
				3'b100:  o_mem_op = MEM_LBU;
				3'b101:  o_mem_op = MEM_LHU;
				default: o_mem_op = MEM_NONE;
			endcase
		end else if (stype) begin
			case (funct3)
				3'b000:  o_mem_op = MEM_SB;
				3'b001:  o_mem_op = MEM_SH;
				3'b010:  o_mem_op = MEM_SW;
				default: o_mem_op = MEM_NONE;
			endcase
		end
	end

	// stall overrides, targets are computed in execute
	always_comb begin
		if (i_stall)
			o_pc_sel = PCSEL_HOLD;
		else if (btype | jtype | jalr)
			o_pc_sel = PCSEL_JUMP;
		else
			o_pc_sel = PCSEL_SEQ;
	end

	// shifts take shamt, other i-formats the immediate
	always_comb begin
		if (shift_imm)
			o_b_sel = BSEL_SHAMT;
		else if (itype | jalr | ltype)
			o_b_sel = BSEL_IMM;
		else
			o_b_sel = BSEL_REG;
	end

	assign o_we = rtype | itype | jtype | jalr | ltype | lui_op | auipc_op | system;

	assign o_j          = jtype;
	assign o_jr         = jalr;
	assign o_bneq       = btype & (funct3 == 3'b001);
	assign o_btype      = btype;
	assign o_lui        = lui_op;
	assign o_auipc      = auipc_op;
	// mul/div op code is funct3 itself
	assign o_mul_div_op = mul_div ? funct3 : 3'b000;
	// ecall vs ebreak by funct12
	assign o_ecall      = system & (funct3 == 3'b000) & (funct12 == 12'd0);

	// source usage for the hazard check
	assign o_rs1_used = rtype | itype | ltype | stype | btype | jrtype | system;
	assign o_rs2_used = rtype | btype | stype;

endmodule

// File: rtl/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch #(
	parameter int ADDR_W = 12
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// wishbone classic read port
	output logic                  o_wb_cyc,
	output logic                  o_wb_stb,
	output logic [ADDR_W-1:0]     o_wb_adr,
	input  rv_decode_pkg::instr_t i_wb_dat,
	input  logic                  i_wb_ack,
	// towards decode and scoreboard
	input  logic                  i_issue,
	output logic                  o_valid,
	output rv_decode_pkg::instr_t o_instr,
	output rv_decode_pkg::word_t  o_pc
);
	import rv_decode_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_HOLD
	} fetch_state_e;

	fetch_state_e state;
	fetch_state_e state_next;
	word_t        pc;
	// one-entry buffer, valid only in hold
	instr_t       instr_buf;

	// one classic read per instruction
	always_comb begin
		state_next = state;
		case (state)
			// idle lasts one cycle before the request
			ST_IDLE:    state_next = ST_REQUEST;
			ST_REQUEST: begin
				if (i_wb_ack)
					state_next = ST_HOLD;
			end
			// keep the word until the scoreboard takes it
			ST_HOLD: begin
				if (i_issue)
					state_next = ST_IDLE;
			end
			default:    state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	// strictly sequential, no redirect
	always_ff @(posedge i_clk) begin
		if (i_reset)
			pc <= '0;
		else if (state == ST_HOLD && i_issue)
			pc <= pc + 32'd4;
	end

	// capture on the ack edge
	always_ff @(posedge i_clk) begin
		if (state == ST_REQUEST && i_wb_ack)
			instr_buf <= i_wb_dat;
	end

	// cyc and stb together, address is the byte pc
	assign o_wb_cyc = (state == ST_REQUEST);
	assign o_wb_stb = (state == ST_REQUEST);
	assign o_wb_adr = pc[ADDR_W-1:0];

	assign o_valid = (state == ST_HOLD);
	assign o_instr = instr_buf;
	assign o_pc    = pc;

endmodule

// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

	// widths with a meaning
	typedef logic [31:0] instr_t;
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// {instr[30], funct3} for arithmetic, fixed codes for branches
	typedef logic [3:0]  alu_fn_t;
	typedef logic [1:0]  b_sel_t;
	typedef logic [1:0]  pc_sel_t;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// operand b source
	localparam b_sel_t BSEL_REG   = 2'd0;
	localparam b_sel_t BSEL_IMM   = 2'd1;
	localparam b_sel_t BSEL_SHAMT = 2'd2;

	// next pc source, resolved later in execute
	localparam pc_sel_t PCSEL_SEQ  = 2'd0;
	localparam pc_sel_t PCSEL_JUMP = 2'd2;
	localparam pc_sel_t PCSEL_HOLD = 2'd3;

	// memory operation, stores have bit 3 set
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LH   = 4'd2,
		MEM_LW   = 4'd3,
		MEM_LBU  = 4'd4,
		MEM_LHU  = 4'd5,
		MEM_SW   = 4'd8,
		MEM_SB   = 4'd14,
		MEM_SH   = 4'd15
	} mem_op_e;

	// writeback result source
	typedef enum logic [2:0] {
		FN_ALU      = 3'd0,
		FN_PC4      = 3'd1,
		FN_MULDIV   = 3'd2,
		FN_IMM      = 3'd3,
		FN_AUIPC    = 3'd4,
		FN_LOAD_SYS = 3'd7
	} fn_sel_e;

endpackage
